//--- common/c2c_pkg.sv
// Shared link codes, sizes, timeouts, state codes and the header byte for the chip-to-chip bridge
package c2c_pkg;

    ////////////////////////////////////////
    // Link byte codes
    ////////////////////////////////////////
    localparam logic [7:0] C2C_POLL_REQ       = 8'hA5;
    localparam logic [5:0] C2C_POLL_RESP_MARK = 6'h2D;
    localparam logic [7:0] C2C_IDLE_BYTE      = 8'hFF;

    localparam logic [3:0] C2C_OP_READ  = 4'd1;
    localparam logic [3:0] C2C_OP_WRITE = 4'd2;

    // Timing and sizes
    localparam logic [15:0] C2C_TIMEOUT       = 16'd16;
    localparam int          C2C_START_RETRIES = 8;
    localparam int          C2C_ADDR_W        = 32;
    localparam int          C2C_DATA_W        = 32;
    localparam int          C2C_REG_COUNT     = 16;
    localparam int          C2C_DOORBELL_IDX  = 15;

    ////////////////////////////////////////
    // Host link states
    ////////////////////////////////////////
    localparam logic [3:0] C2C_HST_START_SEND = 4'd0;
    localparam logic [3:0] C2C_HST_START_WAIT = 4'd1;
    localparam logic [3:0] C2C_HST_POLL_REQ   = 4'd2;
    localparam logic [3:0] C2C_HST_POLL_RESP  = 4'd3;
    localparam logic [3:0] C2C_HST_CMD_SEND   = 4'd4;
    localparam logic [3:0] C2C_HST_TURN       = 4'd5;
    localparam logic [3:0] C2C_HST_RESP_HDR   = 4'd6;
    localparam logic [3:0] C2C_HST_RD_BYTES   = 4'd7;
    localparam logic [3:0] C2C_HST_RESP_OUT   = 4'd8;

    // Device link states
    localparam logic [2:0] C2C_DEV_IDLE   = 3'd0;
    localparam logic [2:0] C2C_DEV_RECV   = 3'd1;
    localparam logic [2:0] C2C_DEV_ACCESS = 3'd2;
    localparam logic [2:0] C2C_DEV_RESULT = 3'd3;
    localparam logic [2:0] C2C_DEV_SEND   = 3'd4;

    // Header byte: command from the host, status from the device
    typedef union packed {
        struct packed {
            logic [3:0] rsvd;
            logic [3:0] op;
        } cmd;
        struct packed {
            logic [5:0] mark;
            logic       err_irq;
            logic       done;
        } stat;
    } c2c_hdr_u;

endpackage

//--- c2c_host/c2c_host_link.sv
// Host side of the byte link: start-up, polling, request framing and response collection
`timescale 1ns/1ps

module c2c_host_link (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  logic [c2c_pkg::C2C_ADDR_W-1:0] req_addr,
    input  logic [c2c_pkg::C2C_DATA_W-1:0] req_wdata,
    output logic                          req_ready,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [c2c_pkg::C2C_DATA_W-1:0] resp_rdata,
    output logic                          resp_err,
    output logic                          irq,
    output logic                          link_up,
    output logic                          bus_stuck,
    output logic [7:0]                    io_data_out,
    output logic                          io_oe,
    input  logic [7:0]                    io_data_in
);
    import c2c_pkg::*;

    logic [3:0]  state;
    logic [7:0]  in_q;
    logic [15:0] timer;
    logic [$clog2(C2C_START_RETRIES)-1:0] retries;
    logic [C2C_ADDR_W+C2C_DATA_W-1:0] tx_shift;
    logic [3:0]  tx_cnt;
    logic [1:0]  rx_cnt;
    logic        cmd_write;
    logic        waiting;
    logic        timed_out;
    logic        stat_ok;
    c2c_hdr_u    rx_hdr;
    c2c_hdr_u    tx_hdr;

    assign rx_hdr  = in_q;
    assign stat_ok = (rx_hdr.stat.mark == C2C_POLL_RESP_MARK);

    always_comb begin
        tx_hdr          = '0;
        tx_hdr.cmd.rsvd = 4'h0;
        tx_hdr.cmd.op   = req_write ? C2C_OP_WRITE : C2C_OP_READ;
    end

    // States in which the device owns the bus
    assign waiting = (state == C2C_HST_START_WAIT) || (state == C2C_HST_POLL_RESP) ||
                     (state == C2C_HST_TURN) || (state == C2C_HST_RESP_HDR) ||
                     (state == C2C_HST_RD_BYTES);
    assign timed_out = waiting && (timer == C2C_TIMEOUT - 16'd1);

    // A request is taken only on a good poll status
    assign req_ready = (state == C2C_HST_POLL_RESP) && stat_ok;

    always_ff @(posedge clk) begin
        // Own bytes are masked so they are never mistaken for device replies
        in_q <= io_oe ? C2C_IDLE_BYTE : io_data_in;

        if (!rst_n) begin
            state      <= C2C_HST_START_SEND;
            io_oe      <= 1'b0;
            timer      <= '0;
            retries    <= '0;
            resp_valid <= 1'b0;
            irq        <= 1'b0;
            link_up    <= 1'b0;
            bus_stuck  <= 1'b0;
        end else begin
            timer <= waiting ? timer + 16'd1 : 16'd0;

            if (timed_out) begin
                link_up <= 1'b0;
                io_oe   <= 1'b0;
                state   <= C2C_HST_START_SEND;
                if (retries == C2C_START_RETRIES - 1) begin
                    bus_stuck <= 1'b1;
                end else begin
                    retries <= retries + 1'b1;
                end
            end else begin
                case (state)
                    ////////////////////////////////////////
                    // Start sequence
                    ////////////////////////////////////////
                    C2C_HST_START_SEND: begin
                        if (io_oe) begin
                            io_oe <= 1'b0;
                            state <= C2C_HST_START_WAIT;
                        end else begin
                            io_oe       <= 1'b1;
                            io_data_out <= C2C_POLL_REQ;
                        end
                    end
                    C2C_HST_START_WAIT: begin
                        if (stat_ok) begin
                            link_up     <= 1'b1;
                            retries     <= '0;
                            irq         <= rx_hdr.stat.err_irq;
                            io_oe       <= 1'b1;
                            io_data_out <= C2C_POLL_REQ;
                            state       <= C2C_HST_POLL_REQ;
                        end
                    end

                    ////////////////////////////////////////
                    // Poll loop
                    ////////////////////////////////////////
                    C2C_HST_POLL_REQ: begin
                        io_oe <= 1'b0;
                        state <= C2C_HST_POLL_RESP;
                    end
                    C2C_HST_POLL_RESP: begin
                        if (stat_ok) begin
                            irq   <= rx_hdr.stat.err_irq;
                            io_oe <= 1'b1;
                            if (req_valid) begin
                                io_data_out <= tx_hdr;
                                tx_shift    <= {req_addr, req_wdata};
                                tx_cnt      <= req_write ? 4'd8 : 4'd4;
                                cmd_write   <= req_write;
                                state       <= C2C_HST_CMD_SEND;
                            end else begin
                                io_data_out <= C2C_POLL_REQ;
                                state       <= C2C_HST_POLL_REQ;
                            end
                        end
                    end

                    // Address first, then write data, MSB first
                    C2C_HST_CMD_SEND: begin
                        if (tx_cnt == 4'd0) begin
                            io_oe <= 1'b0;
                            state <= C2C_HST_TURN;
                        end else begin
                            io_data_out <= tx_shift[$bits(tx_shift)-1 -: 8];
                            tx_shift    <= tx_shift << 8;
                            tx_cnt      <= tx_cnt - 4'd1;
                        end
                    end
                    C2C_HST_TURN: begin
                        state <= C2C_HST_RESP_HDR;
                    end
                    C2C_HST_RESP_HDR: begin
                        if (stat_ok && rx_hdr.stat.done) begin
                            resp_err <= rx_hdr.stat.err_irq;
                            if (cmd_write || rx_hdr.stat.err_irq) begin
                                resp_valid <= 1'b1;
                                state      <= C2C_HST_RESP_OUT;
                            end else begin
                                rx_cnt <= '0;
                                state  <= C2C_HST_RD_BYTES;
                            end
                        end
                    end
                    C2C_HST_RD_BYTES: begin
                        resp_rdata <= {resp_rdata[C2C_DATA_W-9:0], in_q};
                        rx_cnt     <= rx_cnt + 2'd1;
                        if (rx_cnt == 2'd3) begin
                            resp_valid <= 1'b1;
                            state      <= C2C_HST_RESP_OUT;
                        end
                    end

                    // Next poll waits until the response is taken
                    C2C_HST_RESP_OUT: begin
                        if (resp_ready) begin
                            resp_valid  <= 1'b0;
                            io_oe       <= 1'b1;
                            io_data_out <= C2C_POLL_REQ;
                            state       <= C2C_HST_POLL_REQ;
                        end
                    end
                    default: begin
                        io_oe <= 1'b0;
                        state <= C2C_HST_START_SEND;
                    end
                endcase
            end
        end
    end

    // Host never drives while it expects the device to answer
    assert property (@(posedge clk) disable iff (!rst_n) waiting |-> !io_oe);

    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> $stable({req_write, req_addr, req_wdata}));

endmodule

//--- verilog/c2c_device_link.sv
// Device side of the byte link: answers polls, decodes commands and runs target accesses
`timescale 1ns/1ps

module c2c_device_link (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [7:0]                    dev_data_in,
    output logic [7:0]                    dev_data_out,
    output logic                          dev_oe,
    input  logic                          irq_in,
    output logic                          tgt_valid,
    input  logic                          tgt_ready,
    output logic                          tgt_write,
    output logic [c2c_pkg::C2C_ADDR_W-1:0] tgt_addr,
    output logic [c2c_pkg::C2C_DATA_W-1:0] tgt_wdata,
    input  logic [c2c_pkg::C2C_DATA_W-1:0] tgt_rdata,
    input  logic                          tgt_err
);
    import c2c_pkg::*;

    logic [2:0]            state;
    logic [7:0]            in_q;
    logic [3:0]            op_q;
    logic [2:0]            byte_idx;
    logic [2:0]            last_idx;
    logic [2:0]            tx_cnt;
    logic [C2C_DATA_W-1:0] tx_shift;
    c2c_hdr_u              rx_hdr;

    function automatic c2c_hdr_u make_stat(input logic flag, input logic done);
        c2c_hdr_u h;
        h.stat.mark    = C2C_POLL_RESP_MARK;
        h.stat.err_irq = flag;
        h.stat.done    = done;
        return h;
    endfunction

    assign rx_hdr = in_q;
    // Writes carry four data bytes after the address
    assign last_idx = (op_q == C2C_OP_WRITE) ? 3'd7 : 3'd3;

    always_ff @(posedge clk) begin
        in_q <= dev_oe ? C2C_IDLE_BYTE : dev_data_in;

        if (!rst_n) begin
            state     <= C2C_DEV_IDLE;
            dev_oe    <= 1'b0;
            tgt_valid <= 1'b0;
            tgt_write <= 1'b0;
        end else begin
            case (state)
                C2C_DEV_IDLE: begin
                    if (in_q == C2C_POLL_REQ) begin
                        dev_oe       <= 1'b1;
                        dev_data_out <= make_stat(irq_in, 1'b0);
                        tx_cnt       <= '0;
                        state        <= C2C_DEV_SEND;
                    end else if (rx_hdr.cmd.rsvd == 4'h0) begin
                        op_q     <= rx_hdr.cmd.op;
                        byte_idx <= '0;
                        state    <= C2C_DEV_RECV;
                    end
                end

                ////////////////////////////////////////
                // Address and write data collection
                ////////////////////////////////////////
                C2C_DEV_RECV: begin
                    if (byte_idx[2]) begin
                        tgt_wdata <= {tgt_wdata[C2C_DATA_W-9:0], in_q};
                    end else begin
                        tgt_addr <= {tgt_addr[C2C_ADDR_W-9:0], in_q};
                    end
                    byte_idx <= byte_idx + 3'd1;
                    if (byte_idx == last_idx) begin
                        if (op_q == C2C_OP_READ || op_q == C2C_OP_WRITE) begin
                            tgt_valid <= 1'b1;
                            tgt_write <= (op_q == C2C_OP_WRITE);
                            state     <= C2C_DEV_ACCESS;
                        end else begin
                            // Unknown opcode, error status and no access
                            dev_oe       <= 1'b1;
                            dev_data_out <= make_stat(1'b1, 1'b1);
                            tx_cnt       <= '0;
                            state        <= C2C_DEV_SEND;
                        end
                    end
                end
                C2C_DEV_ACCESS: begin
                    if (tgt_ready) begin
                        tgt_valid <= 1'b0;
                        state     <= C2C_DEV_RESULT;
                    end
                end
                // Target answer is registered, valid one cycle after acceptance
                C2C_DEV_RESULT: begin
                    dev_oe       <= 1'b1;
                    dev_data_out <= make_stat(tgt_err, 1'b1);
                    tx_shift     <= tgt_rdata;
                    tx_cnt       <= (!tgt_write && !tgt_err) ? 3'd4 : 3'd0;
                    state        <= C2C_DEV_SEND;
                end
                C2C_DEV_SEND: begin
                    if (tx_cnt == 3'd0) begin
                        dev_oe <= 1'b0;
                        state  <= C2C_DEV_IDLE;
                    end else begin
                        dev_data_out <= tx_shift[C2C_DATA_W-1 -: 8];
                        tx_shift     <= tx_shift << 8;
                        tx_cnt       <= tx_cnt - 3'd1;
                    end
                end
                default: begin
                    dev_oe <= 1'b0;
                    state  <= C2C_DEV_IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(tgt_valid && dev_oe));

endmodule

//--- verilog/c2c_reg_target.sv
// Device register bank of sixteen words, the doorbell word raises the interrupt
`timescale 1ns/1ps

module c2c_reg_target (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tgt_valid,
    input  logic                          tgt_write,
    input  logic [c2c_pkg::C2C_ADDR_W-1:0] tgt_addr,
    input  logic [c2c_pkg::C2C_DATA_W-1:0] tgt_wdata,
    output logic                          tgt_ready,
    output logic                          tgt_err,
    output logic                          irq,
    output logic [c2c_pkg::C2C_DATA_W-1:0] tgt_rdata
);
    import c2c_pkg::*;

    logic [C2C_DATA_W-1:0] regs [C2C_REG_COUNT];
    logic [$clog2(C2C_REG_COUNT)-1:0] idx;
    logic hit;

    // Word index from byte address
    assign idx = tgt_addr[2 +: $clog2(C2C_REG_COUNT)];
    assign hit = (tgt_addr < C2C_REG_COUNT * 4);
    assign irq = |regs[C2C_DOORBELL_IDX];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < C2C_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            tgt_ready <= 1'b0;
            tgt_err   <= 1'b0;
        end else begin
            tgt_ready <= 1'b1;
            if (tgt_valid && tgt_ready) begin
                if (hit && tgt_write) begin
                    regs[idx] <= tgt_wdata;
                end
                tgt_rdata <= hit ? regs[idx] : '0;
                tgt_err   <= !hit;
            end
        end
    end

endmodule

//--- verilog/c2c_bridge_top.sv
// Bridge top level joining host link, device link and register bank over one byte bus
`timescale 1ns/1ps

module c2c_bridge_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic                          req_write,
    input  logic [c2c_pkg::C2C_ADDR_W-1:0] req_addr,
    input  logic [c2c_pkg::C2C_DATA_W-1:0] req_wdata,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [c2c_pkg::C2C_DATA_W-1:0] resp_rdata,
    output logic                          resp_err,
    output logic                          irq,
    output logic                          link_up,
    output logic                          bus_stuck
);
    import c2c_pkg::*;

    logic [7:0]            io_data_out;
    logic                  io_oe;
    logic [7:0]            dev_data_out;
    logic                  dev_oe;
    logic [7:0]            link_bus;
    logic                  dev_irq;
    logic                  tgt_valid;
    logic                  tgt_ready;
    logic                  tgt_write;
    logic [C2C_ADDR_W-1:0] tgt_addr;
    logic [C2C_DATA_W-1:0] tgt_wdata;
    logic [C2C_DATA_W-1:0] tgt_rdata;
    logic                  tgt_err;

    // Shared bus floats high when nobody drives
    assign link_bus = io_oe  ? io_data_out  :
                      dev_oe ? dev_data_out : C2C_IDLE_BYTE;

    c2c_host_link c2c_host_link_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_write   (req_write),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_ready  (resp_ready),
        .resp_rdata  (resp_rdata),
        .resp_err    (resp_err),
        .irq         (irq),
        .link_up     (link_up),
        .bus_stuck   (bus_stuck),
        .io_data_out (io_data_out),
        .io_oe       (io_oe),
        .io_data_in  (link_bus)
    );

    c2c_device_link c2c_device_link_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .dev_data_in  (link_bus),
        .dev_data_out (dev_data_out),
        .dev_oe       (dev_oe),
        .irq_in       (dev_irq),
        .tgt_valid    (tgt_valid),
        .tgt_ready    (tgt_ready),
        .tgt_write    (tgt_write),
        .tgt_addr     (tgt_addr),
        .tgt_wdata    (tgt_wdata),
        .tgt_rdata    (tgt_rdata),
        .tgt_err      (tgt_err)
    );

    c2c_reg_target c2c_reg_target_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .tgt_valid (tgt_valid),
        .tgt_write (tgt_write),
        .tgt_addr  (tgt_addr),
        .tgt_wdata (tgt_wdata),
        .tgt_ready (tgt_ready),
        .tgt_err   (tgt_err),
        .irq       (dev_irq),
        .tgt_rdata (tgt_rdata)
    );

    // Turnaround keeps the two drivers apart
    assert property (@(posedge clk) disable iff (!rst_n) !(io_oe && dev_oe));

endmodule

//--- dv/c2c_bridge_tb.sv
// Directed testbench for the bridge top that runs as the simulation top from all.f
`timescale 1ns/1ps

module c2c_bridge_tb;
    import c2c_pkg::*;

    localparam int RESET_CYCLES    = 16;
    localparam int FRAME_CYCLES    = 20;
    localparam int POLL_CYCLES     = 6;
    localparam int WAIT_LIMIT      = int'(C2C_TIMEOUT) * FRAME_CYCLES;
    localparam int START_LIMIT     = C2C_START_RETRIES * int'(C2C_TIMEOUT);
    localparam int ACCESS_COUNT    = 41;
    localparam int WATCHDOG_CYCLES = ACCESS_COUNT * 60 + RESET_CYCLES + START_LIMIT;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    logic                  req_write;
    logic [C2C_ADDR_W-1:0] req_addr;
    logic [C2C_DATA_W-1:0] req_wdata;
    logic                  resp_valid;
    logic                  resp_ready;
    logic [C2C_DATA_W-1:0] resp_rdata;
    logic                  resp_err;
    logic                  irq;
    logic                  link_up;
    logic                  bus_stuck;

    // Register contents the testbench expects
    logic [C2C_DATA_W-1:0] exp_regs [C2C_REG_COUNT];
    logic [31:0]           lcg_state;

    c2c_bridge_top c2c_bridge_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp_rdata (resp_rdata),
        .resp_err   (resp_err),
        .irq        (irq),
        .link_up    (link_up),
        .bus_stuck  (bus_stuck)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Compare tasks and helpers
    ////////////////////////////////////////
    task automatic check_data(input logic [C2C_DATA_W-1:0] got,
                              input logic [C2C_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s (got %b, expected %b)", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s (resp_err %b, expected %b)", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "wait limit exceeded");
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        lcg_state = lcg_step(lcg_state);
        value     = lcg_state;
    endtask

    // Runs one request and its response and returns on a falling edge
    task automatic do_access(input logic write, input logic [C2C_ADDR_W-1:0] addr,
                             input logic [C2C_DATA_W-1:0] wdata, input int hold,
                             output logic [C2C_DATA_W-1:0] rdata, output logic err);
        int waited;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        waited    = 0;
        while (!req_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("request was never accepted");
        end
        @(negedge clk);
        req_valid = 1'b0;
        waited    = 0;
        while (!resp_valid) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) abort_on_timeout("no response arrived");
        end
        rdata = resp_rdata;
        err   = resp_err;
        // Back-pressure window
        repeat (hold) begin
            check_flag(resp_valid, 1'b1, "resp_valid held under back-pressure");
            check_data(resp_rdata, rdata, "resp_rdata held under back-pressure");
            check_err(resp_err, err, "resp_err held under back-pressure");
            check_flag(req_ready, 1'b0, "req_ready low until response taken");
            @(negedge clk);
        end
        resp_ready = 1'b1;
        @(negedge clk);
        resp_ready = 1'b0;
        check_flag(resp_valid, 1'b0, "resp_valid drops after handshake");
    endtask

    task automatic write_reg(input logic [C2C_ADDR_W-1:0] addr,
                             input logic [C2C_DATA_W-1:0] data, input logic exp_err);
        logic [C2C_DATA_W-1:0] rdata;
        logic                  err;
        do_access(1'b1, addr, data, 0, rdata, err);
        check_err(err, exp_err, "write response");
    endtask

    task automatic read_reg(input logic [C2C_ADDR_W-1:0] addr,
                            input logic [C2C_DATA_W-1:0] exp, input logic exp_err);
        logic [C2C_DATA_W-1:0] rdata;
        logic                  err;
        do_access(1'b0, addr, '0, 0, rdata, err);
        check_err(err, exp_err, "read response");
        if (!exp_err) check_data(rdata, exp, "read data");
    endtask

    task automatic wait_irq(input logic level, input string what);
        int waited;
        waited = 0;
        while (irq !== level) begin
            @(negedge clk);
            waited++;
            if (waited > 2 * POLL_CYCLES) abort_on_timeout(what);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_link_start();
        int waited;
        check_flag(req_ready, 1'b0, "req_ready low after reset");
        check_flag(resp_valid, 1'b0, "resp_valid low after reset");
        check_flag(irq, 1'b0, "irq low after reset");
        check_flag(link_up, 1'b0, "link_up low after reset");
        waited = 0;
        while (!link_up) begin
            @(negedge clk);
            waited++;
            if (waited > START_LIMIT) abort_on_timeout("link_up did not rise after reset");
        end
        check_flag(irq, 1'b0, "irq low after start-up");
    endtask

    task automatic test_reg_readback();
        logic [31:0] value;
        for (int i = 0; i < C2C_REG_COUNT; i++) begin
            draw_random(value);
            exp_regs[i] = value;
            write_reg(32'(i * 4), value, 1'b0);
        end
        for (int i = 0; i < C2C_REG_COUNT; i++) begin
            read_reg(32'(i * 4), exp_regs[i], 1'b0);
        end
    endtask

    // Bits 5:2 cleared so the bad address aliases register 0
    task automatic test_bad_address();
        logic [31:0] bad_addr;
        logic [31:0] value;
        draw_random(bad_addr);
        bad_addr = (bad_addr & 32'hFFFF_FFC3) | 32'h0000_0040;
        draw_random(value);
        write_reg(bad_addr, value, 1'b1);
        read_reg(bad_addr, '0, 1'b1);
        read_reg(32'h0, exp_regs[0], 1'b0);
    endtask

    task automatic test_doorbell_irq();
        logic [31:0] value;
        logic [31:0] bell_addr;
        bell_addr = 32'(C2C_DOORBELL_IDX * 4);
        write_reg(bell_addr, '0, 1'b0);
        wait_irq(1'b0, "irq did not fall after clearing the doorbell");
        draw_random(value);
        value = value | 32'h1;
        write_reg(bell_addr, value, 1'b0);
        wait_irq(1'b1, "irq did not rise within two poll cycles");
        write_reg(bell_addr, '0, 1'b0);
        wait_irq(1'b0, "irq did not fall within two poll cycles");
        exp_regs[C2C_DOORBELL_IDX] = '0;
    endtask

    task automatic test_resp_backpressure();
        logic [31:0]           r;
        logic [C2C_DATA_W-1:0] rdata;
        logic                  err;
        int                    idx;
        draw_random(r);
        idx = int'(r % 32'd15);
        draw_random(r);
        do_access(1'b0, 32'(idx * 4), '0, int'(r % 32'd10) + 1, rdata, err);
        check_err(err, 1'b0, "held read response");
        check_data(rdata, exp_regs[idx], "held read data");
        draw_random(r);
        exp_regs[idx] = r;
        draw_random(r);
        do_access(1'b1, 32'(idx * 4), exp_regs[idx], int'(r % 32'd10) + 1, rdata, err);
        check_err(err, 1'b0, "held write response");
        read_reg(32'(idx * 4), exp_regs[idx], 1'b0);
    endtask

    ////////////////////////////////////////
    // Monitors and sequence
    ////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) check_flag(bus_stuck, 1'b0, "bus_stuck stays low");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired: tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog");
    end

    initial begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        resp_ready = 1'b0;
        lcg_state  = 32'd36;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        test_link_start();
        test_reg_readback();
        test_bad_address();
        test_doorbell_irq();
        test_resp_backpressure();
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- all.f
common/c2c_pkg.sv
c2c_host/c2c_host_link.sv
verilog/c2c_device_link.sv
verilog/c2c_reg_target.sv
verilog/c2c_bridge_top.sv
dv/c2c_bridge_tb.sv

//--- Makefile
TOP := c2c_bridge_tb
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) --Mdir $(OBJ) -o $(TOP)

run: compile
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)
